// File: all.f
+incdir+rtl
rtl/acc_pkg.sv
rtl/xfer_if.sv
rtl/cfg_regs.sv
rtl/xfer_seq.sv
rtl/ext_port_ctrl.sv
rtl/acc_top.sv
testbench/dram_model.sv
testbench/acc_props.sv
testbench/acc_tb.sv

// File: testbench/acc_tb.sv
`timescale 1ns/1ps
`include "acc_defs.svh"

module acc_tb;

    localparam int MEM_WORDS = 1024;
    localparam int MAX_JOBS  = 16;
    localparam int MAX_RB    = 8;
    localparam int CLK_HALF  = 2;

    // Register offsets
    localparam logic [4:0] A_CTRL   = 5'h00;
    localparam logic [4:0] A_SRC    = 5'h04;
    localparam logic [4:0] A_DST    = 5'h08;
    localparam logic [4:0] A_LEN    = 5'h0C;
    localparam logic [4:0] A_OP     = 5'h10;
    localparam logic [4:0] A_ARG    = 5'h14;
    localparam logic [4:0] A_STATUS = 5'h18;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [4:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        dat_oe;
    logic        cmd_vld;
    logic        net_fnh;
    logic        stall_en;
    wire [`ACC_DAT_W-1:0] dat;
    wire         dat_vld;
    wire         dat_rdy;

    // Expected DRAM contents
    logic [31:0] shadow [MEM_WORDS];
    int          seed = 32'h75f3;

    // Job table
    string        t_name    [MAX_JOBS];
    logic [15:0]  t_src     [MAX_JOBS];
    logic [15:0]  t_dst     [MAX_JOBS];
    int           t_len     [MAX_JOBS];
    acc_pkg::op_e t_op      [MAX_JOBS];
    logic [31:0]  t_arg     [MAX_JOBS];
    logic         t_stall   [MAX_JOBS];
    logic         t_restart [MAX_JOBS];
    int           n_jobs = 0;

    // Register readback table
    logic [4:0]  rb_addr  [MAX_RB];
    logic [31:0] rb_wdata [MAX_RB];
    logic [31:0] rb_exp   [MAX_RB];
    int          n_rb = 0;

    int err_cnt   = 0;
    int test_cnt  = 0;
    int test_fail = 0;
    int fnh_cnt   = 0;
    int cycle_cnt = 0;
    int cycle_lim = 0;

    // ========================================
    // DUT and memory
    // ========================================
    acc_top dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .dat_oe  (dat_oe),
        .cmd_vld (cmd_vld),
        .net_fnh (net_fnh),
        .dat     (dat),
        .dat_vld (dat_vld),
        .dat_rdy (dat_rdy)
    );

    dram_model u_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall_en (stall_en),
        .dat_oe   (dat_oe),
        .cmd_vld  (cmd_vld),
        .dat      (dat),
        .dat_vld  (dat_vld),
        .dat_rdy  (dat_rdy)
    );

    initial clk = 1'b0;
    always #(CLK_HALF) clk = ~clk;

    // Finish pulses seen so far
    always @(posedge clk) begin
        if (net_fnh === 1'b1) fnh_cnt <= fnh_cnt + 1;
    end

    // Run limit from the table length
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_lim > 0 && cycle_cnt >= cycle_lim) begin
            $display("Timeout: DUT did not finish within %0d cycles", cycle_lim);
            $display("Done: errors found");
            $finish;
        end
    end

    // ========================================
    // Helpers
    // ========================================
    task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [4:0] addr, output logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        // Mid-cycle, away from the edge
        #1;
        data = prdata;
        // No wait states on the slave
        compare_word("pready", 32'd1, pready);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        assert (got === exp) else begin
            $display("FAIL t=%0t %s: expected %h, actual %h", $time, name, exp, got);
            err_cnt++;
        end
    endtask

    // Opcode rules from the register map
    function automatic logic [31:0] transform_word(input acc_pkg::op_e op,
                                                   input logic [31:0] w,
                                                   input logic [31:0] a);
        case (op)
            acc_pkg::OP_ADD: return w + a;
            acc_pkg::OP_XOR: return w ^ a;
            acc_pkg::OP_NEG: return 32'd0 - w;
            default:         return w;
        endcase
    endfunction

    task automatic add_job(input string name, input logic [15:0] src, input logic [15:0] dst,
                           input int len, input acc_pkg::op_e op, input logic [31:0] arg,
                           input logic stall, input logic restart);
        t_name[n_jobs]    = name;
        t_src[n_jobs]     = src;
        t_dst[n_jobs]     = dst;
        t_len[n_jobs]     = len;
        t_op[n_jobs]      = op;
        t_arg[n_jobs]     = arg;
        t_stall[n_jobs]   = stall;
        t_restart[n_jobs] = restart;
        n_jobs++;
    endtask

    task automatic add_readback(input logic [4:0] addr, input logic [31:0] wdata,
                                input logic [31:0] exp);
        rb_addr[n_rb]  = addr;
        rb_wdata[n_rb] = wdata;
        rb_exp[n_rb]   = exp;
        n_rb++;
    endtask

    // Whole source read first, so overlap follows the original words
    task automatic update_shadow(input int j);
        logic [31:0] tmp [`ACC_BUF_DEPTH];
        for (int i = 0; i < t_len[j]; i++) begin
            tmp[i] = shadow[t_src[j] + i];
        end
        for (int i = 0; i < t_len[j]; i++) begin
            shadow[t_dst[j] + i] = transform_word(t_op[j], tmp[i], t_arg[j]);
        end
    endtask

    task automatic check_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            compare_word($sformatf("mem[%0d]", i), shadow[i], u_mem.mem[i]);
        end
    endtask

    task automatic close_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
            test_fail++;
        end
    endtask

    task automatic run_job(input int j);
        logic [31:0] rd;
        int          fnh_before;
        stall_en = t_stall[j];
        apb_write(A_SRC, {16'd0, t_src[j]});
        apb_write(A_DST, {16'd0, t_dst[j]});
        apb_write(A_LEN, t_len[j]);
        apb_write(A_OP, {30'd0, t_op[j]});
        apb_write(A_ARG, t_arg[j]);
        fnh_before = fnh_cnt;
        apb_write(A_CTRL, 32'h1);
        // Busy set, done cleared by the start
        apb_read(A_STATUS, rd);
        compare_word("STATUS while busy", 32'h1, rd);
        if (t_restart[j]) begin
            apb_write(A_CTRL, 32'h1);
            apb_read(A_STATUS, rd);
            compare_word("STATUS after restart", 32'h1, rd);
        end
        while (fnh_cnt == fnh_before) @(negedge clk);
        // Room for a stray second pulse
        repeat (4) @(negedge clk);
        apb_read(A_STATUS, rd);
        compare_word("STATUS after job", 32'h2, rd);
        compare_word("net_fnh pulses", 32'd1, fnh_cnt - fnh_before);
        update_shadow(j);
        check_memory();
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        int          errs;
        int          total;
        logic [31:0] rd;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        stall_en = 1'b0;
        rst_n    = 1'b0;

        add_readback(A_SRC, 32'h0000_1234, 32'h0000_1234);
        add_readback(A_DST, 32'h0000_abcd, 32'h0000_abcd);
        add_readback(A_LEN, 32'd0, 32'd1);
        add_readback(A_LEN, 32'd9, 32'd9);
        add_readback(A_OP, 32'd3, 32'd3);
        add_readback(A_ARG, 32'hdead_beef, 32'hdead_beef);

        add_job("pass", 16'd0, 16'd100, 8, acc_pkg::OP_PASS, 32'h0, 1'b0, 1'b0);
        add_job("add", 16'd20, 16'd120, 16, acc_pkg::OP_ADD, 32'h1357_9bdf, 1'b0, 1'b0);
        add_job("xor", 16'd40, 16'd140, 5, acc_pkg::OP_XOR, 32'ha5a5_0ff0, 1'b0, 1'b0);
        add_job("neg", 16'd60, 16'd160, 12, acc_pkg::OP_NEG, 32'h0, 1'b0, 1'b0);
        // Stalled copies land in fresh regions
        add_job("pass stall", 16'd0, 16'd500, 8, acc_pkg::OP_PASS, 32'h0, 1'b1, 1'b0);
        add_job("add stall", 16'd20, 16'd520, 16, acc_pkg::OP_ADD, 32'h1357_9bdf, 1'b1, 1'b0);
        add_job("xor stall", 16'd40, 16'd540, 5, acc_pkg::OP_XOR, 32'ha5a5_0ff0, 1'b1, 1'b0);
        add_job("neg stall", 16'd60, 16'd560, 12, acc_pkg::OP_NEG, 32'h0, 1'b1, 1'b0);
        add_job("overlap", 16'd200, 16'd204, 16, acc_pkg::OP_ADD, 32'h0000_0101, 1'b0, 1'b0);
        // Overlapped ADD, a second run would change the result
        add_job("restart", 16'd300, 16'd303, 10, acc_pkg::OP_ADD, 32'h0000_0010, 1'b0, 1'b1);

        total = 0;
        for (int j = 0; j < n_jobs; j++) begin
            total += t_len[j];
        end
        cycle_lim = total * 8 + 200;

        // Random fill, mixed with the word address
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i]    = $random(seed) ^ i;
            u_mem.mem[i] = shadow[i];
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Port idle after reset
        errs = err_cnt;
        compare_word("cmd_vld", 32'd0, cmd_vld);
        compare_word("dat_oe", 32'd0, dat_oe);
        compare_word("net_fnh", 32'd0, net_fnh);
        close_test("reset state", errs);

        errs = err_cnt;
        for (int i = 0; i < n_rb; i++) begin
            apb_write(rb_addr[i], rb_wdata[i]);
            apb_read(rb_addr[i], rd);
            compare_word($sformatf("reg 0x%02h", rb_addr[i]), rb_exp[i], rd);
        end
        close_test("register readback", errs);

        for (int j = 0; j < n_jobs; j++) begin
            errs = err_cnt;
            run_job(j);
            close_test(t_name[j], errs);
        end

        $display("Tests: %0d run, %0d failed, %0d errors, %0d assertion failures",
                 test_cnt, test_fail, err_cnt, dut.u_props.prop_errs);
        if (err_cnt == 0 && dut.u_props.prop_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: testbench/acc_props.sv
`timescale 1ns/1ps
`include "acc_defs.svh"

module acc_props (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  dat_oe,
    input logic                  cmd_vld,
    input logic                  net_fnh,
    input logic [`ACC_DAT_W-1:0] dat,
    input logic                  dat_vld,
    input logic                  dat_rdy
);

    // Failure tally, read by the testbench at the end
    int unsigned prop_errs = 0;
    logic        beat;

    assign beat = (dat_vld === 1'b1) && (dat_rdy === 1'b1);

    // ========================================
    // Port rules
    // ========================================

    // cmd_vld with dat_oe only in the first cycle of a command
    a_cmd_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_vld && dat_oe) |-> !$past(dat_oe))
    else begin
        $error("cmd_vld pulsed while the chip held the data phase");
        prop_errs++;
    end

    // Chip data must be known whenever it offers a beat
    a_dat_known: assert property (@(posedge clk) disable iff (!rst_n)
        (dat_oe && dat_vld) |-> !$isunknown(dat))
    else begin
        $error("dat unknown while the chip drives dat_vld");
        prop_errs++;
    end

    // Finish is a single-cycle pulse
    a_fnh_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        net_fnh |=> !net_fnh)
    else begin
        $error("net_fnh held for more than one cycle");
        prop_errs++;
    end

    // No beat across a turnaround
    a_beat_stable: assert property (@(posedge clk) disable iff (!rst_n)
        beat |-> $stable(dat_oe))
    else begin
        $error("beat in the same cycle as a dat_oe change");
        prop_errs++;
    end

endmodule

bind acc_top acc_props u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .dat_oe  (dat_oe),
    .cmd_vld (cmd_vld),
    .net_fnh (net_fnh),
    .dat     (dat),
    .dat_vld (dat_vld),
    .dat_rdy (dat_rdy)
);

// File: testbench/dram_model.sv
`timescale 1ns/1ps
`include "acc_defs.svh"

module dram_model (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall_en,
    input  logic                  dat_oe,
    input  logic                  cmd_vld,
    inout  wire [`ACC_DAT_W-1:0]  dat,
    inout  wire                   dat_vld,
    inout  wire                   dat_rdy
);

    localparam int MEM_WORDS = 1024;

    // Word array, filled by the testbench at time zero
    logic [`ACC_DAT_W-1:0]  mem [MEM_WORDS];

    // IDLE, CMD, IN2CHIP, OUT2OFF
    acc_pkg::port_phase_e   state;
    logic [`ACC_ADDR_W-1:0] addr;
    logic                   stall;
    logic                   beat;
    int                     seed = 32'h75f3;

    // ========================================
    // Pad drivers
    // ========================================

    // Memory owns dat and dat_vld while dat_oe is low
    assign dat     = dat_oe ? {`ACC_DAT_W{1'bz}} : mem[addr[9:0]];
    assign dat_vld = dat_oe ? 1'bz : ((state == acc_pkg::PH_IN) && !stall);
    // Ready toward the chip for the command word and write data
    assign dat_rdy = dat_oe ? (((state == acc_pkg::PH_CMD) || (state == acc_pkg::PH_OUT))
                               && !stall) : 1'bz;

    assign beat = dat_vld & dat_rdy;

    // ========================================
    // Protocol FSM
    // ========================================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= acc_pkg::PH_IDLE;
            addr  <= '0;
            stall <= 1'b0;
        end else begin
            // Random drop of vld or rdy, one cycle at a time
            if (stall_en) begin
                stall <= (($random(seed) & 3) == 0);
            end else begin
                stall <= 1'b0;
            end
            case (state)
                acc_pkg::PH_IDLE: if (cmd_vld) state <= acc_pkg::PH_CMD;
                acc_pkg::PH_CMD: begin
                    // Bit 0 picks the direction, bits 16:1 the start word
                    if (beat) begin
                        addr  <= dat[`ACC_ADDR_W:1];
                        state <= dat[0] ? acc_pkg::PH_OUT : acc_pkg::PH_IN;
                    end
                end
                acc_pkg::PH_IN, acc_pkg::PH_OUT: begin
                    if (cmd_vld) begin
                        state <= acc_pkg::PH_IDLE;
                    end else if (beat) begin
                        addr <= addr + 1'b1;
                    end
                end
                default: state <= acc_pkg::PH_IDLE;
            endcase
        end
    end

    // Write beats land at the current word
    always @(posedge clk) begin
        if (state == acc_pkg::PH_OUT && !cmd_vld && beat) begin
            mem[addr[9:0]] <= dat;
        end
    end

endmodule

// File: rtl/acc_top.sv
`timescale 1ns/1ps
`include "acc_defs.svh"

module acc_top (
    input  logic                  clk,
    input  logic                  rst_n,
    // APB configuration
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [4:0]            paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    // DRAM port
    output logic                  dat_oe,
    output logic                  cmd_vld,
    output logic                  net_fnh,
    inout  wire [`ACC_DAT_W-1:0]  dat,
    inout  wire                   dat_vld,
    inout  wire                   dat_rdy
);

    logic                   start;
    logic [`ACC_ADDR_W-1:0] src;
    logic [`ACC_ADDR_W-1:0] dst;
    logic [`ACC_LEN_W-1:0]  len;
    acc_pkg::op_e           op;
    logic [`ACC_DAT_W-1:0]  arg;
    logic                   busy;

    xfer_if xfer ();

    // ========================================
    // Instances
    // ========================================
    cfg_regs u_cfg (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .start   (start),
        .src     (src),
        .dst     (dst),
        .len     (len),
        .op      (op),
        .arg     (arg),
        .busy    (busy),
        .fin     (net_fnh)
    );

    // Finish pulse goes straight out as net_fnh
    xfer_seq u_seq (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .src   (src),
        .dst   (dst),
        .len   (len),
        .op    (op),
        .arg   (arg),
        .busy  (busy),
        .fin   (net_fnh),
        .xfer  (xfer.seq)
    );

    ext_port_ctrl u_port (
        .clk     (clk),
        .rst_n   (rst_n),
        .xfer    (xfer.port),
        .dat_oe  (dat_oe),
        .cmd_vld (cmd_vld),
        .dat     (dat),
        .dat_vld (dat_vld),
        .dat_rdy (dat_rdy)
    );

endmodule

// File: rtl/ext_port_ctrl.sv
`timescale 1ns/1ps
`include "acc_defs.svh"

module ext_port_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    xfer_if.port                  xfer,
    output logic                  dat_oe,
    output logic                  cmd_vld,
    inout  wire [`ACC_DAT_W-1:0]  dat,
    inout  wire                   dat_vld,
    inout  wire                   dat_rdy
);

    acc_pkg::port_phase_e phase;

    // Chip side of the handshake
    logic                  vld_q;
    logic                  rdy_q;
    logic [`ACC_LEN_W-1:0] beat_cnt;
    logic                  beat;
    logic                  last_beat;
    logic [`ACC_DAT_W-1:0] cmd_word;
    logic [`ACC_DAT_W-1:0] dat_out;

    // ========================================
    // Pad drivers
    // ========================================

    // Bit 0 write flag, bits 16:1 word address
    assign cmd_word = {{(`ACC_DAT_W - `ACC_ADDR_W - 1){1'b0}}, xfer.req_addr, xfer.req_wr};
    assign dat_out  = (phase == acc_pkg::PH_OUT) ? xfer.tx_dat : cmd_word;

    // dat_oe decides who owns each wire
    assign dat     = dat_oe ? dat_out : {`ACC_DAT_W{1'bz}};
    assign dat_vld = dat_oe ? vld_q : 1'bz;
    assign dat_rdy = dat_oe ? 1'bz : rdy_q;

    // Transfer on both high, whichever side drives
    assign beat      = dat_vld & dat_rdy;
    assign last_beat = (beat_cnt == xfer.req_len - 1'b1);

    assign xfer.tx_take  = (phase == acc_pkg::PH_OUT) && beat;
    // One cycle after the closing cmd_vld
    assign xfer.req_done = (phase == acc_pkg::PH_END) && !cmd_vld;

    // ========================================
    // Phase sequencing
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase       <= acc_pkg::PH_IDLE;
            cmd_vld     <= 1'b0;
            dat_oe      <= 1'b0;
            vld_q       <= 1'b0;
            rdy_q       <= 1'b0;
            beat_cnt    <= '0;
            xfer.rx_vld <= 1'b0;
        end else begin
            // Pulses by default
            cmd_vld     <= 1'b0;
            xfer.rx_vld <= 1'b0;
            case (phase)
                acc_pkg::PH_IDLE: begin
                    // Wake memory and offer the command word
                    if (xfer.req) begin
                        cmd_vld  <= 1'b1;
                        dat_oe   <= 1'b1;
                        vld_q    <= 1'b1;
                        beat_cnt <= '0;
                        phase    <= acc_pkg::PH_CMD;
                    end
                end
                acc_pkg::PH_CMD: begin
                    if (beat && xfer.req_wr) begin
                        phase <= acc_pkg::PH_OUT;
                    end else if (beat) begin
                        // Hand the bus to memory
                        dat_oe <= 1'b0;
                        vld_q  <= 1'b0;
                        phase  <= acc_pkg::PH_IN;
                    end
                end
                acc_pkg::PH_OUT: begin
                    if (beat) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            vld_q   <= 1'b0;
                            dat_oe  <= 1'b0;
                            cmd_vld <= 1'b1;
                            phase   <= acc_pkg::PH_END;
                        end
                    end
                end
                acc_pkg::PH_IN: begin
                    if (beat) begin
                        xfer.rx_vld <= 1'b1;
                        beat_cnt    <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            rdy_q   <= 1'b0;
                            cmd_vld <= 1'b1;
                            phase   <= acc_pkg::PH_END;
                        end
                    end else begin
                        // Turnaround cycle, then ready
                        rdy_q <= 1'b1;
                    end
                end
                acc_pkg::PH_END: begin
                    if (!cmd_vld) phase <= acc_pkg::PH_IDLE;
                end
                default: phase <= acc_pkg::PH_IDLE;
            endcase
        end
    end

    // Read word capture
    always_ff @(posedge clk) begin
        if (phase == acc_pkg::PH_IN && beat) begin
            xfer.rx_dat <= dat;
        end
    end

endmodule

// File: rtl/xfer_seq.sv
`timescale 1ns/1ps
`include "acc_defs.svh"

module xfer_seq (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic [`ACC_ADDR_W-1:0] src,
    input  logic [`ACC_ADDR_W-1:0] dst,
    input  logic [`ACC_LEN_W-1:0]  len,
    input  acc_pkg::op_e           op,
    input  logic [`ACC_DAT_W-1:0]  arg,
    output logic                   busy,
    output logic                   fin,
    xfer_if.seq                    xfer
);

    localparam int PTR_W = $clog2(`ACC_BUF_DEPTH);

    acc_pkg::seq_state_e state;
    acc_pkg::seq_state_e state_nxt;

    // Job copy taken at start
    logic [`ACC_ADDR_W-1:0] src_q;
    logic [`ACC_ADDR_W-1:0] dst_q;
    logic [`ACC_LEN_W-1:0]  len_q;
    acc_pkg::op_e           op_q;
    logic [`ACC_DAT_W-1:0]  arg_q;

    logic [`ACC_DAT_W-1:0]  wbuf [`ACC_BUF_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [`ACC_DAT_W-1:0]  xf_dat;
    logic                   wr_phase;

    // ========================================
    // FSM
    // ========================================
    always_comb begin
        state_nxt = state;
        case (state)
            acc_pkg::ST_IDLE:   if (start)         state_nxt = acc_pkg::ST_RD_REQ;
            // First word in marks the data phase
            acc_pkg::ST_RD_REQ: if (xfer.rx_vld)   state_nxt = acc_pkg::ST_RD_DAT;
            acc_pkg::ST_RD_DAT: if (xfer.req_done) state_nxt = acc_pkg::ST_WR_REQ;
            acc_pkg::ST_WR_REQ: if (xfer.tx_take)  state_nxt = acc_pkg::ST_WR_DAT;
            acc_pkg::ST_WR_DAT: if (xfer.req_done) state_nxt = acc_pkg::ST_FIN;
            acc_pkg::ST_FIN:    state_nxt = acc_pkg::ST_IDLE;
            default:            state_nxt = acc_pkg::ST_IDLE;
        endcase
    end

    // State and buffer pointers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= acc_pkg::ST_IDLE;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            state <= state_nxt;
            if (state == acc_pkg::ST_IDLE) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
            end else begin
                if (xfer.rx_vld) wr_ptr <= wr_ptr + 1'b1;
                if (xfer.tx_take) rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Latch the job so APB writes mid-job have no effect
    always_ff @(posedge clk) begin
        if (state == acc_pkg::ST_IDLE && start) begin
            src_q <= src;
            dst_q <= dst;
            len_q <= len;
            op_q  <= op;
            arg_q <= arg;
        end
    end

    // ========================================
    // Opcode unit and buffer
    // ========================================
    always_comb begin
        case (op_q)
            acc_pkg::OP_PASS: xf_dat = xfer.rx_dat;
            acc_pkg::OP_ADD:  xf_dat = xfer.rx_dat + arg_q;
            acc_pkg::OP_XOR:  xf_dat = xfer.rx_dat ^ arg_q;
            // Two's complement
            acc_pkg::OP_NEG:  xf_dat = ~xfer.rx_dat + 1'b1;
            default:          xf_dat = xfer.rx_dat;
        endcase
    end

    // Whole job lands here before any write, so overlap is safe
    always_ff @(posedge clk) begin
        if (xfer.rx_vld) begin
            wbuf[wr_ptr] <= xf_dat;
        end
    end

    // ========================================
    // Request side
    // ========================================
    assign wr_phase = (state == acc_pkg::ST_WR_REQ) || (state == acc_pkg::ST_WR_DAT);

    assign xfer.req      = (state == acc_pkg::ST_RD_REQ) || (state == acc_pkg::ST_RD_DAT) ||
                           wr_phase;
    assign xfer.req_wr   = wr_phase;
    assign xfer.req_addr = wr_phase ? dst_q : src_q;
    assign xfer.req_len  = len_q;
    // Next word to go out, advances on tx_take
    assign xfer.tx_dat   = wbuf[rd_ptr];

    assign busy = (state != acc_pkg::ST_IDLE);
    assign fin  = (state == acc_pkg::ST_FIN);

endmodule

// File: rtl/cfg_regs.sv
`timescale 1ns/1ps
`include "acc_defs.svh"

module cfg_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [4:0]             paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   start,
    output logic [`ACC_ADDR_W-1:0] src,
    output logic [`ACC_ADDR_W-1:0] dst,
    output logic [`ACC_LEN_W-1:0]  len,
    output acc_pkg::op_e           op,
    output logic [`ACC_DAT_W-1:0]  arg,
    input  logic                   busy,
    input  logic                   fin
);

    // Register offsets
    localparam logic [4:0] A_CTRL   = 5'h00;
    localparam logic [4:0] A_SRC    = 5'h04;
    localparam logic [4:0] A_DST    = 5'h08;
    localparam logic [4:0] A_LEN    = 5'h0C;
    localparam logic [4:0] A_OP     = 5'h10;
    localparam logic [4:0] A_ARG    = 5'h14;
    localparam logic [4:0] A_STATUS = 5'h18;

    localparam logic [`ACC_LEN_W-1:0] LEN_MAX = `ACC_BUF_DEPTH;

    logic                  wr_en;
    logic                  done;
    logic [`ACC_LEN_W-1:0] len_wr;

    // ========================================
    // APB write decode
    // ========================================

    // No wait states
    assign pready = 1'b1;
    // Access phase of a write
    assign wr_en  = psel & penable & pwrite;

    // Length clamp into 1..16
    always_comb begin
        if (pwdata == 32'd0) begin
            len_wr = 1;
        end else if (pwdata > `ACC_BUF_DEPTH) begin
            len_wr = LEN_MAX;
        end else begin
            len_wr = pwdata[`ACC_LEN_W-1:0];
        end
    end

    // Single-cycle start, dropped while a job runs
    // Own pulse also blocks, busy rises one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start <= 1'b0;
        end else begin
            start <= wr_en && (paddr == A_CTRL) && pwdata[0] && !busy && !start;
        end
    end

    // Job registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src <= '0;
            dst <= '0;
            len <= 1;
            op  <= acc_pkg::OP_PASS;
            arg <= '0;
        end else if (wr_en) begin
            case (paddr)
                A_SRC:   src <= pwdata[`ACC_ADDR_W-1:0];
                A_DST:   dst <= pwdata[`ACC_ADDR_W-1:0];
                A_LEN:   len <= len_wr;
                A_OP:    op  <= acc_pkg::op_e'(pwdata[1:0]);
                A_ARG:   arg <= pwdata;
                default: ;
            endcase
        end
    end

    // Sticky done, cleared by an accepted start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else if (start) begin
            done <= 1'b0;
        end else if (fin) begin
            done <= 1'b1;
        end
    end

    // ========================================
    // APB read mux
    // ========================================
    always_comb begin
        prdata = '0;
        case (paddr)
            A_SRC:    prdata[`ACC_ADDR_W-1:0] = src;
            A_DST:    prdata[`ACC_ADDR_W-1:0] = dst;
            A_LEN:    prdata[`ACC_LEN_W-1:0]  = len;
            A_OP:     prdata[1:0]             = op;
            A_ARG:    prdata                  = arg;
            A_STATUS: prdata[1:0]             = {done, busy};
            // CTRL reads as zero
            default:  prdata                  = '0;
        endcase
    end

endmodule

// File: rtl/xfer_if.sv
`timescale 1ns/1ps
`include "acc_defs.svh"

interface xfer_if;

    // Request side, held until req_done
    logic                   req;
    logic                   req_wr;
    logic [`ACC_ADDR_W-1:0] req_addr;
    logic [`ACC_LEN_W-1:0]  req_len;
    logic                   req_done;

    // Read beats toward the buffer
    logic                   rx_vld;
    logic [`ACC_DAT_W-1:0]  rx_dat;

    // Write beats from the buffer
    logic [`ACC_DAT_W-1:0]  tx_dat;
    logic                   tx_take;

    modport seq (
        output req, req_wr, req_addr, req_len, tx_dat,
        input  req_done, rx_vld, rx_dat, tx_take
    );

    modport port (
        input  req, req_wr, req_addr, req_len, tx_dat,
        output req_done, rx_vld, rx_dat, tx_take
    );

endinterface

// File: rtl/acc_pkg.sv
package acc_pkg;

    // Job sequencer states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_REQ,
        ST_RD_DAT,
        ST_WR_REQ,
        ST_WR_DAT,
        ST_FIN
    } seq_state_e;

    // DRAM port phases, first four mirror the memory side
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_CMD,
        PH_IN,
        PH_OUT,
        PH_END
    } port_phase_e;

    // Per-word transform applied on arrival
    typedef enum logic [1:0] {
        OP_PASS,
        OP_ADD,
        OP_XOR,
        OP_NEG
    } op_e;

endpackage

// File: rtl/acc_defs.svh
`ifndef ACC_DEFS_SVH
`define ACC_DEFS_SVH

// Data word on the DRAM port and the APB side
`define ACC_DAT_W 32

// DRAM word address, carried in command bits 16:1
`define ACC_ADDR_W 16

// Job length field, holds 1 to 16
`define ACC_LEN_W 5

// Local buffer depth, also the longest job
`define ACC_BUF_DEPTH 16

`endif
